// File: audio_soc_cfg.svh
// Build constants for the audio subsystem: UART bit timing, FIFO depth, sample rate, DAC width
`ifndef AUDIO_SOC_CFG_SVH
`define AUDIO_SOC_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial input
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// System clocks per UART bit
`define AUDIO_SOC_CLKS_PER_BIT 16

// Byte buffer entries, kept a power of two so the pointers wrap on their own
`define AUDIO_SOC_FIFO_DEPTH 16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Playback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// System clocks between two sample ticks
`define AUDIO_SOC_SAMPLE_PERIOD 1024

// Width of both modulator accumulators
`define AUDIO_SOC_ACC_W 24

`endif

// File: audio_soc_pkg.sv
// Shared types of the audio path: received UART byte and PCM sample
`default_nettype none

package audio_soc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // UART receive payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One byte off the serial line plus its stop-bit check
    typedef struct packed {
        logic [7:0] data;
        // High when the stop bit was sampled low
        logic       frame_err;
    } rx_byte_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Audio samples
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Two's complement 16-bit PCM, sent low byte first on the wire
    typedef logic signed [15:0] pcm_t;

endpackage

`default_nettype wire

// File: uart_byte_rx.sv
// UART receiver: input synchronizer, bit timer and frame FSM producing one byte per frame
`timescale 1ns/1ps
`default_nettype none
`include "audio_soc_cfg.svh"

module uart_byte_rx (
    input  logic                    ext_clk_100_i,
    input  logic                    rst_i,
    input  logic                    rx_i,
    output audio_soc_pkg::rx_byte_t rx_byte_o,
    output logic                    rx_valid_o
);

    localparam int CLKS  = `AUDIO_SOC_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    logic                    rx_meta;
    logic                    rx_sync;
    logic                    rx_prev;
    logic                    start_edge;
    logic                    bit_done;
    state_t                  state_q;
    logic [CNT_W-1:0]        tick_cnt_q;
    logic [2:0]              bit_idx_q;
    logic [7:0]              shift_q;
    audio_soc_pkg::rx_byte_t rx_byte_q;
    logic                    rx_valid_q;

    // Two flops against metastability, a third one to see the falling edge
    always_ff @(posedge ext_clk_100_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync;
    assign bit_done   = (tick_cnt_q == BIT_LAST);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge ext_clk_100_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            tick_cnt_q <= '0;
            bit_idx_q  <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_edge) begin
                        state_q    <= ST_START;
                        tick_cnt_q <= '0;
                    end
                end
                ST_START: begin
                    // Half a bit on, the line must still be low or it was a glitch
                    if (tick_cnt_q == HALF_LAST) begin
                        tick_cnt_q <= '0;
                        bit_idx_q  <= '0;
                        state_q    <= rx_sync ? ST_IDLE : ST_DATA;
                    end else begin
                        tick_cnt_q <= tick_cnt_q + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (bit_done) begin
                        tick_cnt_q <= '0;
                        bit_idx_q  <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= ST_STOP;
                        end
                    end else begin
                        tick_cnt_q <= tick_cnt_q + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        rx_valid_q <= 1'b1;
                        state_q    <= ST_IDLE;
                    end else begin
                        tick_cnt_q <= tick_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first, so they shift in from the top
    always_ff @(posedge ext_clk_100_i) begin
        if (state_q == ST_DATA && bit_done) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (state_q == ST_STOP && bit_done) begin
            rx_byte_q.data      <= shift_q;
            rx_byte_q.frame_err <= ~rx_sync;
        end
    end

    assign rx_byte_o  = rx_byte_q;
    assign rx_valid_o = rx_valid_q;

endmodule

`default_nettype wire

// File: byte_fifo.sv
// Circular byte buffer between the UART receiver and the sample player
`timescale 1ns/1ps
`default_nettype none
`include "audio_soc_cfg.svh"

module byte_fifo (
    input  logic                                         ext_clk_100_i,
    input  logic                                         rst_i,
    input  logic                                         wr_i,
    input  audio_soc_pkg::rx_byte_t                      wr_data_i,
    input  logic                                         rd_i,
    output audio_soc_pkg::rx_byte_t                      rd_data_o,
    output logic [$clog2(`AUDIO_SOC_FIFO_DEPTH + 1)-1:0] count_o,
    output logic                                         overflow_o
);

    localparam int DEPTH = `AUDIO_SOC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    audio_soc_pkg::rx_byte_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             overflow_q;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count_q == CNT_W'(DEPTH));
    assign do_wr = wr_i & ~full;
    assign do_rd = rd_i & (count_q != '0);

    // Storage only, the pointers decide what is valid
    always_ff @(posedge ext_clk_100_i) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge ext_clk_100_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count_q <= count_q + 1'b1;
            end else if (do_rd && !do_wr) begin
                count_q <= count_q - 1'b1;
            end
            // The line cannot be stalled, so a byte landing on a full buffer is lost
            if (wr_i && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assign rd_data_o  = mem[rd_ptr_q];
    assign count_o    = count_q;
    assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// File: delta_sigma_dac.sv
// Second-order delta-sigma modulator turning a PCM sample into a one-bit stream
`timescale 1ns/1ps
`default_nettype none
`include "audio_soc_cfg.svh"

module delta_sigma_dac (
    input  logic                ext_clk_100_i,
    input  logic                rst_i,
    input  audio_soc_pkg::pcm_t pcm_i,
    output logic                dac_o,
    output logic                acc1_overflow_o,
    output logic                acc2_overflow_o
);

    localparam int W = `AUDIO_SOC_ACC_W;
    localparam logic signed [W-1:0] FB_POS = W'(32767);
    localparam logic signed [W-1:0] FB_NEG = W'(-32768);

    logic signed [W-1:0] acc1_q;
    logic signed [W-1:0] acc2_q;
    logic signed [W-1:0] fb;
    logic signed [W-1:0] pcm_ext;
    logic signed [W-1:0] delta1;
    logic signed [W-1:0] acc1_d;
    logic signed [W-1:0] delta2;
    logic signed [W-1:0] acc2_d;
    logic                ovf1;
    logic                ovf2;
    logic                dac_q;
    logic                ovf1_q;
    logic                ovf2_q;

    // Quantizer feedback follows the bit currently on the pin
    assign fb      = dac_q ? FB_POS : FB_NEG;
    assign pcm_ext = W'(pcm_i);

    assign delta1 = pcm_ext - fb;
    assign acc1_d = acc1_q + delta1;
    assign delta2 = acc1_d - fb;
    assign acc2_d = acc2_q + delta2;

    // Signed overflow: both addends share a sign that the sum does not
    assign ovf1 = (acc1_q[W-1] == delta1[W-1]) && (acc1_d[W-1] != acc1_q[W-1]);
    assign ovf2 = (acc2_q[W-1] == delta2[W-1]) && (acc2_d[W-1] != acc2_q[W-1]);

    // Flags are registered with the sums they describe, the bit lags one more cycle
    always_ff @(posedge ext_clk_100_i) begin
        if (rst_i) begin
            acc1_q <= '0;
            acc2_q <= '0;
            ovf1_q <= 1'b0;
            ovf2_q <= 1'b0;
            dac_q  <= 1'b0;
        end else begin
            acc1_q <= acc1_d;
            acc2_q <= acc2_d;
            ovf1_q <= ovf1;
            ovf2_q <= ovf2;
            dac_q  <= ~acc2_q[W-1];
        end
    end

    assign dac_o           = dac_q;
    assign acc1_overflow_o = ovf1_q;
    assign acc2_overflow_o = ovf2_q;

endmodule

`default_nettype wire

// File: pcm_sample_player.sv
// Sample player: rate timer, byte-pair sequencer, sticky error flags and the modulator
`timescale 1ns/1ps
`default_nettype none
`include "audio_soc_cfg.svh"

module pcm_sample_player (
    input  logic                                         ext_clk_100_i,
    input  logic                                         rst_i,
    input  audio_soc_pkg::rx_byte_t                      fifo_data_i,
    input  logic [$clog2(`AUDIO_SOC_FIFO_DEPTH + 1)-1:0] fifo_count_i,
    output logic                                         fifo_pop_o,
    output audio_soc_pkg::pcm_t                          pcm_o,
    output logic                                         sample_strobe_o,
    output logic                                         underrun_o,
    output logic                                         frame_err_o,
    output logic                                         audio_out_o,
    output logic                                         acc1_overflow_o,
    output logic                                         acc2_overflow_o
);

    localparam int PERIOD = `AUDIO_SOC_SAMPLE_PERIOD;
    localparam int TMR_W  = $clog2(PERIOD);
    localparam int CNT_W  = $clog2(`AUDIO_SOC_FIFO_DEPTH + 1);
    localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(PERIOD - 1);

    typedef enum logic {
        ST_WAIT,
        ST_POP_HI
    } state_t;

    logic [TMR_W-1:0]        tmr_q;
    logic                    tick;
    logic                    have_pair;
    logic                    pair_err;
    state_t                  state_q;
    audio_soc_pkg::rx_byte_t lo_q;
    audio_soc_pkg::pcm_t     pcm_q;
    logic                    strobe_q;
    logic                    underrun_q;
    logic                    frame_err_q;

    assign tick      = (tmr_q == TMR_LAST);
    assign have_pair = (fifo_count_i >= CNT_W'(2));
    assign pair_err  = lo_q.frame_err | fifo_data_i.frame_err;

    // Low byte goes in the tick cycle, high byte right after it
    assign fifo_pop_o = (state_q == ST_POP_HI) | ((state_q == ST_WAIT) & tick & have_pair);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Rate timer and pair sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge ext_clk_100_i) begin
        if (rst_i) begin
            tmr_q       <= '0;
            state_q     <= ST_WAIT;
            pcm_q       <= '0;
            strobe_q    <= 1'b0;
            underrun_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            tmr_q    <= tick ? '0 : tmr_q + 1'b1;
            strobe_q <= 1'b0;
            case (state_q)
                ST_WAIT: begin
                    if (tick && have_pair) begin
                        state_q <= ST_POP_HI;
                    end else if (tick) begin
                        // Nothing to play, the previous sample keeps going
                        underrun_q <= 1'b1;
                    end
                end
                ST_POP_HI: begin
                    pcm_q    <= pair_err ? '0 :
                                audio_soc_pkg::pcm_t'({fifo_data_i.data, lo_q.data});
                    strobe_q <= 1'b1;
                    if (pair_err) begin
                        frame_err_q <= 1'b1;
                    end
                    state_q <= ST_WAIT;
                end
                default: state_q <= ST_WAIT;
            endcase
        end
    end

    // Holds the low byte until its partner arrives
    always_ff @(posedge ext_clk_100_i) begin
        if (state_q == ST_WAIT && tick && have_pair) begin
            lo_q <= fifo_data_i;
        end
    end

    delta_sigma_dac dac_inst (
        .ext_clk_100_i   (ext_clk_100_i),
        .rst_i           (rst_i),
        .pcm_i           (pcm_q),
        .dac_o           (audio_out_o),
        .acc1_overflow_o (acc1_overflow_o),
        .acc2_overflow_o (acc2_overflow_o)
    );

    assign pcm_o           = pcm_q;
    assign sample_strobe_o = strobe_q;
    assign underrun_o      = underrun_q;
    assign frame_err_o     = frame_err_q;

endmodule

`default_nettype wire

// File: audio_soc_top.sv
// Board top of the audio path: UART pin, status LEDs, audio pin and simulation observation ports
`timescale 1ns/1ps
`default_nettype none
`include "audio_soc_cfg.svh"

module audio_soc_top (
    input  logic                ext_clk_100_i,
    input  logic                rst_i,
    input  logic                uart_rx_i,
    output logic                audio_out_o,
    output logic                overflow_led_o,
    output logic                underrun_led_o,
    output logic                frame_err_led_o,
    // Observation ports, left open on the board and watched in simulation
    output audio_soc_pkg::pcm_t pcm_out_o,
    output logic                sample_strobe_o,
    output logic                acc1_overflow_o,
    output logic                acc2_overflow_o
);

    audio_soc_pkg::rx_byte_t                      rx_byte;
    logic                                         rx_valid;
    audio_soc_pkg::rx_byte_t                      fifo_head;
    logic [$clog2(`AUDIO_SOC_FIFO_DEPTH + 1)-1:0] fifo_count;
    logic                                         fifo_pop;

    uart_byte_rx uart_rx_inst (
        .ext_clk_100_i (ext_clk_100_i),
        .rst_i         (rst_i),
        .rx_i          (uart_rx_i),
        .rx_byte_o     (rx_byte),
        .rx_valid_o    (rx_valid)
    );

    byte_fifo byte_fifo_inst (
        .ext_clk_100_i (ext_clk_100_i),
        .rst_i         (rst_i),
        .wr_i          (rx_valid),
        .wr_data_i     (rx_byte),
        .rd_i          (fifo_pop),
        .rd_data_o     (fifo_head),
        .count_o       (fifo_count),
        .overflow_o    (overflow_led_o)
    );

    pcm_sample_player player_inst (
        .ext_clk_100_i   (ext_clk_100_i),
        .rst_i           (rst_i),
        .fifo_data_i     (fifo_head),
        .fifo_count_i    (fifo_count),
        .fifo_pop_o      (fifo_pop),
        .pcm_o           (pcm_out_o),
        .sample_strobe_o (sample_strobe_o),
        .underrun_o      (underrun_led_o),
        .frame_err_o     (frame_err_led_o),
        .audio_out_o     (audio_out_o),
        .acc1_overflow_o (acc1_overflow_o),
        .acc2_overflow_o (acc2_overflow_o)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// Testbench clock and reset source: 10 ns clock, reset held ten cycles at start and on request
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    input  logic restart_i,
    output logic clk_o,
    output logic rst_o
);

    localparam int RST_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset leaves time zero asserted and can be pulsed again by the test sequence
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
        forever begin
            @(posedge clk_o);
            if (restart_i) begin
                rst_o <= 1'b1;
                repeat (RST_CYCLES) @(posedge clk_o);
                rst_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_audio_soc.sv
// Testbench of the audio path: UART stimulus, LFSR, reference models, checker, watchdog, report
`timescale 1ns/1ps
`default_nettype none
`include "audio_soc_cfg.svh"

module tb_audio_soc;

    localparam int CLKS         = `AUDIO_SOC_CLKS_PER_BIT;
    localparam int PERIOD       = `AUDIO_SOC_SAMPLE_PERIOD;
    localparam int ACC_W        = `AUDIO_SOC_ACC_W;
    localparam int TOTAL_FRAMES = 64;
    localparam int WDOG_CYCLES  = 2 * (TOTAL_FRAMES * 10 * CLKS + 20 * PERIOD);

    // Modulator state as the checker tracks it
    typedef struct packed {
        logic [ACC_W-1:0] acc1;
        logic [ACC_W-1:0] acc2;
        logic             dac;
        logic             ovf1;
        logic             ovf2;
    } dsm_state_t;

    logic                clk;
    logic                rst;
    logic                restart = 1'b0;
    logic                uart_rx = 1'b1;
    logic                audio_out;
    logic                overflow_led;
    logic                underrun_led;
    logic                frame_err_led;
    audio_soc_pkg::pcm_t pcm_out;
    logic                strobe;
    logic                acc1_ovf;
    logic                acc2_ovf;

    logic [15:0] exp_q[$];
    logic [31:0] lfsr_q       = 32'h25dad095;
    dsm_state_t  model_q;
    logic        model_valid  = 1'b0;
    logic        pcm_check_en = 1'b1;
    int          err_count    = 0;
    int          check_count  = 0;
    int          ovf_seen     = 0;

    tb_clk_gen clk_gen_inst (
        .restart_i (restart),
        .clk_o     (clk),
        .rst_o     (rst)
    );

    audio_soc_top UUT (
        .ext_clk_100_i   (clk),
        .rst_i           (rst),
        .uart_rx_i       (uart_rx),
        .audio_out_o     (audio_out),
        .overflow_led_o  (overflow_led),
        .underrun_led_o  (underrun_led),
        .frame_err_led_o (frame_err_led),
        .pcm_out_o       (pcm_out),
        .sample_strobe_o (strobe),
        .acc1_overflow_o (acc1_ovf),
        .acc2_overflow_o (acc2_ovf)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // A pair with a bad stop bit in either byte plays as silence
    function automatic logic [15:0] expected_sample(input logic [7:0] lo, input logic [7:0] hi,
                                                    input logic lo_bad, input logic hi_bad);
        if (lo_bad || hi_bad) begin
            return 16'h0000;
        end
        return {hi, lo};
    endfunction

    function automatic dsm_state_t dsm_step(input dsm_state_t s, input logic signed [15:0] pcm);
        dsm_state_t       n;
        longint           fb;
        longint           lim_hi;
        longint           lim_lo;
        longint           sum1;
        longint           sum2;
        logic [ACC_W-1:0] d1;
        logic [ACC_W-1:0] d2;
        lim_hi = (longint'(1) << (ACC_W - 1)) - longint'(1);
        lim_lo = -lim_hi - longint'(1);
        fb     = s.dac ? longint'(32767) : longint'(-32768);
        d1     = ACC_W'(longint'(pcm) - fb);
        sum1   = longint'($signed(s.acc1)) + longint'($signed(d1));
        n.acc1 = ACC_W'(sum1);
        n.ovf1 = (sum1 > lim_hi) || (sum1 < lim_lo);
        d2     = ACC_W'(longint'($signed(n.acc1)) - fb);
        sum2   = longint'($signed(s.acc2)) + longint'($signed(d2));
        n.acc2 = ACC_W'(sum2);
        n.ovf2 = (sum2 > lim_hi) || (sum2 < lim_lo);
        // The bit on the pin follows the sign of the accumulator one cycle late
        n.dac  = longint'($signed(s.acc2)) >= longint'(0);
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got %h expected %h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("Error: %s at %0t", what, $time);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished with %0d errors", name, err_count - errs_before);
    endtask

    task automatic rand_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[14:0], lfsr_q[0]};
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        uart_rx <= b;
        repeat (CLKS - 1) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_ok);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_ok);
    endtask

    task automatic send_sample(input logic [15:0] value, input logic hi_bad);
        exp_q.push_back(expected_sample(value[7:0], value[15:8], 1'b0, hi_bad));
        send_frame(value[7:0], 1'b1);
        send_frame(value[15:8], ~hi_bad);
        if (hi_bad) begin
            // Line back to idle so the next start bit has a falling edge
            drive_bit(1'b1);
        end
    endtask

    task automatic wait_queue_empty(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        expect_true(exp_q.size() == 0, "expected samples were never strobed out");
    endtask

    task automatic check_leds_dark();
        check_value("pcm_out_o", pcm_out, 16'h0000);
        check_value("overflow_led_o", 16'(overflow_led), 16'h0000);
        check_value("underrun_led_o", 16'(underrun_led), 16'h0000);
        check_value("frame_err_led_o", 16'(frame_err_led), 16'h0000);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checker, runs on the falling edge where every output is settled
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (model_valid) begin
            check_value("audio_out_o", 16'(audio_out), 16'(model_q.dac));
            check_value("acc1_overflow_o", 16'(acc1_ovf), 16'(model_q.ovf1));
            check_value("acc2_overflow_o", 16'(acc2_ovf), 16'(model_q.ovf2));
            if (acc1_ovf || acc2_ovf) begin
                ovf_seen++;
            end
        end
        if (strobe && pcm_check_en) begin
            expect_true(exp_q.size() != 0, "sample strobe with no sample expected");
            if (exp_q.size() != 0) begin
                check_value("pcm_out_o", pcm_out, exp_q.pop_front());
            end
        end
        // pcm_out is stable here and is what the modulator takes at the next edge
        if (rst) begin
            model_q     = '0;
            model_valid = 1'b1;
        end else if (model_valid) begin
            model_q = dsm_step(model_q, pcm_out);
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int          errs;
        int          i;
        logic [15:0] v;

        // Reset state, then the first tick finds an empty buffer
        @(posedge clk);
        while (rst) @(posedge clk);
        errs = err_count;
        @(negedge clk);
        check_leds_dark();
        i = 0;
        while (!underrun_led && i < PERIOD + 8) begin
            @(negedge clk);
            i++;
        end
        expect_true(underrun_led, "underrun LED did not light after the first sample tick");
        report_test("1 reset state and underrun", errs);

        errs = err_count;
        for (i = 0; i < 8; i++) begin
            rand_bits(16, v);
            send_sample(v, 1'b0);
            idle_cycles(PERIOD);
        end
        wait_queue_empty(3 * PERIOD);
        @(negedge clk);
        check_value("frame_err_led_o", 16'(frame_err_led), 16'h0000);
        report_test("2 random samples", errs);

        errs = err_count;
        rand_bits(16, v);
        send_sample(v, 1'b1);
        idle_cycles(PERIOD);
        rand_bits(16, v);
        send_sample(v, 1'b0);
        idle_cycles(PERIOD);
        wait_queue_empty(3 * PERIOD);
        @(negedge clk);
        check_value("frame_err_led_o", 16'(frame_err_led), 16'h0001);
        report_test("3 framing error", errs);

        // Full scale both ways drives the accumulators past their range
        errs     = err_count;
        ovf_seen = 0;
        send_sample(16'h7fff, 1'b0);
        idle_cycles(4 * PERIOD);
        send_sample(16'h8000, 1'b0);
        idle_cycles(4 * PERIOD);
        wait_queue_empty(3 * PERIOD);
        expect_true(ovf_seen != 0, "no accumulator overflow seen with full-scale samples");
        report_test("4 modulator and full scale", errs);

        // Dropped bytes break the pairing, so only the modulator is followed here
        errs         = err_count;
        pcm_check_en = 1'b0;
        for (i = 0; i < 40; i++) begin
            rand_bits(8, v);
            send_frame(v[7:0], 1'b1);
        end
        idle_cycles(2 * CLKS);
        @(negedge clk);
        check_value("overflow_led_o", 16'(overflow_led), 16'h0001);
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        while (!rst) @(posedge clk);
        while (rst) @(posedge clk);
        @(negedge clk);
        check_leds_dark();
        exp_q.delete();
        report_test("5 overflow and reset", errs);

        $display("Summary: 5 tests, %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: audio_soc.f
+incdir+.
audio_soc_pkg.sv
uart_byte_rx.sv
byte_fifo.sv
delta_sigma_dac.sv
pcm_sample_player.sv
audio_soc_top.sv
tb_clk_gen.sv
tb_audio_soc.sv

// File: Makefile
# Verilator build and run for the audio path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_audio_soc
FILELIST  ?= audio_soc.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
